// File: build.f
source/csr_pkg.sv
source/csr_decode.sv
source/csr_timer.sv
source/csr_file.sv
source/csr_unit.sv
test/csr_unit_checks.sv
test/csr_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the csr unit testbench with verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module csr_unit_tb -f build.f -o csr_unit_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/csr_unit_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
   exit 0
fi
exit 1

// File: test/csr_unit_tb.sv
module csr_unit_tb;
   timeunit 1ns;
   timeprecision 1ps;

   logic              clk;
   logic              rst_n;
   csr_pkg::csr_req_t req;
   csr_pkg::csr_exc_t exc;
   logic              ext_intr;
   csr_pkg::csr_rsp_t rsp;
   logic [31:0]       eentry;
   logic [31:0]       era;
   logic              crmd_ie;
   logic              timer_intr;
   int                test_id;
   int                errors;
   int                fails;
   logic [13:0]       all_addrs [10];

   always #2 clk = ~clk;

   csr_unit uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .exc        (exc),
      .ext_intr   (ext_intr),
      .rsp        (rsp),
      .eentry     (eentry),
      .era        (era),
      .crmd_ie    (crmd_ie),
      .timer_intr (timer_intr)
   );

   csr_unit_checks chk (
      .clk        (clk),
      .rst_n      (rst_n),
      .test_id    (test_id),
      .req        (req),
      .exc        (exc),
      .ext_intr   (ext_intr),
      .rsp        (rsp),
      .eentry     (eentry),
      .era        (era),
      .crmd_ie    (crmd_ie),
      .timer_intr (timer_intr),
      .errors     (errors)
   );

   function automatic csr_pkg::csr_req_t access(input logic [13:0] raddr,
                                                input logic [13:0] waddr,
                                                input logic [31:0] wdata,
                                                input logic [31:0] mask, input logic wen);
      csr_pkg::csr_req_t r;
      r.valid = 1'b1;
      r.raddr = raddr;
      r.waddr = waddr;
      r.wdata = wdata;
      r.mask = mask;
      r.wen = wen;
      return r;
   endfunction

   function automatic csr_pkg::csr_exc_t make_exc(input logic valid, input logic ertn,
                                                  input logic [5:0] ecode,
                                                  input logic [31:0] pc,
                                                  input logic [31:0] badv);
      csr_pkg::csr_exc_t e;
      e.valid = valid;
      e.ertn = ertn;
      e.ecode = ecode;
      e.pc = pc;
      e.badv = badv;
      return e;
   endfunction

   // one cycle of execute-stage traffic
   task automatic step(input csr_pkg::csr_req_t r, input csr_pkg::csr_exc_t e);
      @(posedge clk);
      req <= r;
      exc <= e;
   endtask

   task automatic read_csr(input logic [13:0] addr);
      step(access(addr, addr, '0, '0, 1'b0), '0);
   endtask

   // reads the same address, so the response carries the old value
   task automatic write_csr(input logic [13:0] addr, input logic [31:0] data,
                            input logic [31:0] mask);
      step(access(addr, addr, data, mask, 1'b1), '0);
   endtask

   // latency is fixed, four idle cycles flush both stages and the checks
   task automatic drain();
      repeat (4) step('0, '0);
   endtask

   task automatic wait_timer(input logic level, input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (timer_intr !== level && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (timer_intr !== level) begin
         fails++;
         $display("timeout: timer_intr did not reach %0d within %0d cycles", level, limit);
      end
   endtask

   task automatic hold_low(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         if (timer_intr) begin
            fails++;
            $display("timer_intr rose again after a one-shot run was cleared");
            break;
         end
      end
   endtask

   initial begin
      logic [13:0] waddr;
      logic [31:0] initval_word;
      void'($urandom(32'h1976));
      clk = 1'b0;
      rst_n = 1'b0;
      req = '0;
      exc = '0;
      ext_intr = 1'b0;
      test_id = 0;
      fails = 0;
      all_addrs = '{csr_pkg::addr_crmd, csr_pkg::addr_prmd, csr_pkg::addr_estat,
                    csr_pkg::addr_era, csr_pkg::addr_badv, csr_pkg::addr_eentry,
                    csr_pkg::addr_tcfg, csr_pkg::addr_tval, csr_pkg::addr_ticlr,
                    csr_pkg::addr_bsec};
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      test_id = 1;
      for (int i = 0; i < 10; i++) begin
         read_csr(all_addrs[i]);
      end
      read_csr(14'h3ff);
      drain();

      // first six entries are the plain read-write registers
      test_id = 2;
      for (int i = 0; i < 24; i++) begin
         waddr = all_addrs[$urandom % 6];
         write_csr(waddr, $urandom, $urandom);
      end
      for (int i = 0; i < 6; i++) begin
         read_csr(all_addrs[i]);
      end
      drain();

      // crmd write lands on the same edge as the exception
      test_id = 3;
      write_csr(csr_pkg::addr_crmd, $urandom | 32'h4, 32'h7);
      drain();
      step(access(csr_pkg::addr_crmd, csr_pkg::addr_crmd, 32'h7, '1, 1'b1), '0);
      step('0, make_exc(1'b1, 1'b0, 6'($urandom), $urandom, $urandom));
      read_csr(csr_pkg::addr_era);
      read_csr(csr_pkg::addr_badv);
      read_csr(csr_pkg::addr_estat);
      read_csr(csr_pkg::addr_crmd);
      read_csr(csr_pkg::addr_prmd);
      drain();

      test_id = 4;
      write_csr(csr_pkg::addr_prmd, $urandom | 32'h4, 32'h7);
      drain();
      step('0, make_exc(1'b0, 1'b1, '0, '0, '0));
      read_csr(csr_pkg::addr_crmd);
      drain();

      test_id = 5;
      initval_word = (($urandom % 4) + 4) << 2;
      write_csr(csr_pkg::addr_tcfg, initval_word | 32'h1, '1);
      read_csr(csr_pkg::addr_tval);
      step('0, '0);
      step('0, '0);
      read_csr(csr_pkg::addr_tval);
      wait_timer(1'b1, 200);
      write_csr(csr_pkg::addr_ticlr, 32'h1, 32'h1);
      step('0, '0);
      wait_timer(1'b0, 10);
      hold_low(40);
      write_csr(csr_pkg::addr_tcfg, initval_word | 32'h3, '1);
      step('0, '0);
      wait_timer(1'b1, 200);
      write_csr(csr_pkg::addr_ticlr, 32'h1, 32'h1);
      step('0, '0);
      wait_timer(1'b0, 10);
      wait_timer(1'b1, 200);
      write_csr(csr_pkg::addr_tcfg, '0, '1);
      write_csr(csr_pkg::addr_ticlr, 32'h1, 32'h1);
      drain();

      test_id = 6;
      write_csr(csr_pkg::addr_bsec, 32'h1, 32'h1);
      write_csr(csr_pkg::addr_bsec, 32'h0, 32'h1);
      read_csr(csr_pkg::addr_bsec);
      @(posedge clk);
      ext_intr <= 1'b1;
      read_csr(csr_pkg::addr_estat);
      // line stays high until stage two has read estat
      drain();
      ext_intr <= 1'b0;
      read_csr(csr_pkg::addr_estat);
      drain();

      $display("checker errors: %0d, testbench failures: %0d", errors, fails);
      if (errors == 0 && fails == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: test/csr_unit_checks.sv
module csr_unit_checks (
   input  logic                      clk,
   input  logic                      rst_n,
   input  int                        test_id,
   input  csr_pkg::csr_req_t         req,
   input  csr_pkg::csr_exc_t         exc,
   input  logic                      ext_intr,
   input  csr_pkg::csr_rsp_t         rsp,
   input  logic [csr_pkg::grlen-1:0] eentry,
   input  logic [csr_pkg::grlen-1:0] era,
   input  logic                      crmd_ie,
   input  logic                      timer_intr,
   output int                        errors
);
   timeunit 1ns;
   timeprecision 1ps;

   // model of the access held in stage one
   csr_pkg::csr_req_t s1;
   logic              wr;
   logic [1:0]        m_plv;
   logic [1:0]        m_pplv;
   logic [1:0]        m_sis;
   logic              m_ie;
   logic              m_pie;
   logic [5:0]        m_ecode;
   logic [31:0]       m_era;
   logic [31:0]       m_badv;
   logic [31:0]       m_eentry;
   logic              m_en;
   logic              m_periodic;
   logic [29:0]       m_initval;
   logic [31:0]       m_count;
   logic              m_pulse;
   logic              m_done;
   logic              m_ti;
   logic              m_ef;
   logic [31:0]       crmd_new;
   logic [31:0]       prmd_new;
   logic [31:0]       tcfg_new;
   logic              exp_valid;
   logic [31:0]       exp_rdata;

   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                         input logic [31:0] mask);
      return (old & ~mask) | (data & mask);
   endfunction

   function automatic logic writes(input logic [13:0] addr);
      return wr && (s1.waddr == addr);
   endfunction

   // architectural view of each register
   function automatic logic [31:0] read_word(input logic [13:0] addr);
      logic [31:0] w;
      w = '0;
      case (addr)
         csr_pkg::addr_crmd: w = {29'd0, m_ie, m_plv};
         csr_pkg::addr_prmd: w = {29'd0, m_pie, m_pplv};
         csr_pkg::addr_estat: w = {10'd0, m_ecode, 11'd0, ext_intr, m_ti, 1'b0, m_sis};
         csr_pkg::addr_era: w = m_era;
         csr_pkg::addr_badv: w = m_badv;
         csr_pkg::addr_eentry: w = m_eentry;
         csr_pkg::addr_tcfg: w = {m_initval, m_periodic, m_en};
         csr_pkg::addr_tval: w = m_count;
         csr_pkg::addr_bsec: w = {31'd0, m_ef};
         default: w = '0;
      endcase
      return w;
   endfunction

   function automatic string test_label(input int id);
      case (id)
         1: return "reset_values";
         2: return "masked_writes";
         3: return "exception";
         4: return "ertn";
         5: return "timer";
         6: return "bsec_ext_intr";
         default: return "idle";
      endcase
   endfunction

   task automatic report(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
      errors = errors + 1;
      $display("** Error: test %s, %s expected %h actual %h",
               test_label(test_id), what, expected, actual);
   endtask

   initial errors = 0;

   assign wr = s1.valid & s1.wen;
   assign crmd_new = merge({29'd0, m_ie, m_plv}, s1.wdata, s1.mask);
   assign prmd_new = merge({29'd0, m_pie, m_pplv}, s1.wdata, s1.mask);
   assign tcfg_new = merge({m_initval, m_periodic, m_en}, s1.wdata, s1.mask);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1 <= '0;
         exp_valid <= 1'b0;
         exp_rdata <= '0;
         m_plv <= '0;
         m_ie <= 1'b0;
         m_pplv <= '0;
         m_pie <= 1'b0;
         m_sis <= '0;
         m_ecode <= '0;
         m_era <= '0;
         m_badv <= '0;
         m_eentry <= '0;
         m_en <= 1'b0;
         m_periodic <= 1'b0;
         m_initval <= '0;
         m_count <= '0;
         m_pulse <= 1'b0;
         m_done <= 1'b1;
         m_ti <= 1'b0;
         m_ef <= 1'b0;
      end else begin
         s1 <= req;
         exp_valid <= s1.valid;
         // read sees the state before this edge's write
         if (s1.valid) begin
            exp_rdata <= read_word(s1.raddr);
         end
         if (exc.valid) begin
            m_pplv <= m_plv;
            m_pie <= m_ie;
            m_plv <= 2'b00;
            m_ie <= 1'b0;
         end else if (exc.ertn) begin
            m_plv <= m_pplv;
            m_ie <= m_pie;
         end else begin
            if (writes(csr_pkg::addr_crmd)) begin
               m_plv <= crmd_new[1:0];
               m_ie <= crmd_new[2];
            end
            if (writes(csr_pkg::addr_prmd)) begin
               m_pplv <= prmd_new[1:0];
               m_pie <= prmd_new[2];
            end
         end
         if (writes(csr_pkg::addr_estat)) begin
            m_sis <= (m_sis & ~s1.mask[1:0]) | (s1.wdata[1:0] & s1.mask[1:0]);
         end
         if (exc.valid) begin
            m_era <= exc.pc;
            m_badv <= exc.badv;
            m_ecode <= exc.ecode;
         end else begin
            if (writes(csr_pkg::addr_era)) begin
               m_era <= merge(m_era, s1.wdata, s1.mask);
            end
            if (writes(csr_pkg::addr_badv)) begin
               m_badv <= merge(m_badv, s1.wdata, s1.mask);
            end
         end
         if (writes(csr_pkg::addr_eentry)) begin
            m_eentry <= merge(m_eentry, s1.wdata, s1.mask);
         end
         // any tcfg write restarts the countdown from the merged value
         if (writes(csr_pkg::addr_tcfg)) begin
            m_en <= tcfg_new[0];
            m_periodic <= tcfg_new[1];
            m_initval <= tcfg_new[31:2];
            m_count <= {tcfg_new[31:2], 2'b00};
            m_pulse <= 1'b0;
            m_done <= 1'b0;
         end else if (m_en && m_count == '0 && !m_done && !m_pulse) begin
            m_pulse <= 1'b1;
            if (m_periodic) begin
               m_count <= {m_initval, 2'b00};
            end else begin
               m_done <= 1'b1;
            end
         end else begin
            m_pulse <= 1'b0;
            if (m_en && m_count != '0) begin
               m_count <= m_count - 32'd1;
            end
         end
         m_ti <= m_pulse | (m_ti & ~(writes(csr_pkg::addr_ticlr) & s1.wdata[0] & s1.mask[0]));
         m_ef <= m_ef | (writes(csr_pkg::addr_bsec) & s1.wdata[0] & s1.mask[0]);
      end
   end

   a_rsp_valid: assert property (@(posedge clk) disable iff (!rst_n) rsp.valid == exp_valid)
      else report("rsp.valid", {31'd0, $sampled(exp_valid)}, {31'd0, $sampled(rsp.valid)});

   a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      exp_valid |-> rsp.rdata == exp_rdata)
      else report("rdata", $sampled(exp_rdata), $sampled(rsp.rdata));

   a_era: assert property (@(posedge clk) disable iff (!rst_n) era == m_era)
      else report("era", $sampled(m_era), $sampled(era));

   a_eentry: assert property (@(posedge clk) disable iff (!rst_n) eentry == m_eentry)
      else report("eentry", $sampled(m_eentry), $sampled(eentry));

   a_crmd_ie: assert property (@(posedge clk) disable iff (!rst_n) crmd_ie == m_ie)
      else report("crmd_ie", {31'd0, $sampled(m_ie)}, {31'd0, $sampled(crmd_ie)});

   a_timer_intr: assert property (@(posedge clk) disable iff (!rst_n) timer_intr == m_ti)
      else report("timer_intr", {31'd0, $sampled(m_ti)}, {31'd0, $sampled(timer_intr)});

endmodule

// File: source/csr_unit.sv
module csr_unit (
   input  logic                      clk,
   input  logic                      rst_n,
   input  csr_pkg::csr_req_t         req,
   input  csr_pkg::csr_exc_t         exc,
   input  logic                      ext_intr,
   output csr_pkg::csr_rsp_t         rsp,
   output logic [csr_pkg::grlen-1:0] eentry,
   output logic [csr_pkg::grlen-1:0] era,
   output logic                      crmd_ie,
   output logic                      timer_intr
);

   // decoded access between the two stages
   csr_pkg::csr_sel_t sel;

   csr_decode u_decode (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .sel   (sel)
   );

   // exc bypasses stage one
   csr_file u_file (
      .clk        (clk),
      .rst_n      (rst_n),
      .sel        (sel),
      .exc        (exc),
      .ext_intr   (ext_intr),
      .rsp        (rsp),
      .eentry     (eentry),
      .era        (era),
      .crmd_ie    (crmd_ie),
      .timer_intr (timer_intr)
   );

endmodule

// File: source/csr_file.sv
module csr_file (
   input  logic                      clk,
   input  logic                      rst_n,
   input  csr_pkg::csr_sel_t         sel,
   input  csr_pkg::csr_exc_t         exc,
   input  logic                      ext_intr,
   output csr_pkg::csr_rsp_t         rsp,
   output logic [csr_pkg::grlen-1:0] eentry,
   output logic [csr_pkg::grlen-1:0] era,
   output logic                      crmd_ie,
   output logic                      timer_intr
);

   logic [csr_pkg::num_csr-1:0]            wsel_en;
   logic [csr_pkg::grlen-1:0]              wbits;
   logic [csr_pkg::grlen-1:0]              keep;

   logic [1:0]                             crmd_plv;
   logic [1:0]                             crmd_plv_nxt;
   logic                                   crmd_ie_nxt;
   logic [1:0]                             prmd_pplv;
   logic [1:0]                             prmd_pplv_nxt;
   logic                                   prmd_pie;
   logic                                   prmd_pie_nxt;
   logic [1:0]                             estat_sis;
   logic [5:0]                             estat_ecode;
   logic [csr_pkg::grlen-1:0]              badv;
   logic                                   tcfg_en;
   logic                                   tcfg_en_nxt;
   logic                                   tcfg_periodic;
   logic                                   tcfg_periodic_nxt;
   logic [csr_pkg::timer_bits-1:0]         tcfg_initval;
   logic [csr_pkg::timer_bits-1:0]         tcfg_initval_nxt;
   logic                                   bsec_ef;
   logic                                   ti_clear;
   logic                                   timer_pulse;
   logic [csr_pkg::grlen-1:0]              timeval;
   logic [csr_pkg::num_csr-1:0][csr_pkg::grlen-1:0] csr_word;
   logic [csr_pkg::grlen-1:0]              rdata;

   assign wsel_en = sel.wsel & {csr_pkg::num_csr{sel.wen}};
   assign wbits = sel.wdata & sel.mask;
   assign keep = ~sel.mask;
   assign ti_clear = wsel_en[csr_pkg::sel_ticlr] & wbits[csr_pkg::ticlr_clr_bit];

   // next value per field: exception, then ertn, then csr write
   always_comb begin
      crmd_plv_nxt = crmd_plv;
      crmd_ie_nxt = crmd_ie;
      prmd_pplv_nxt = prmd_pplv;
      prmd_pie_nxt = prmd_pie;
      if (exc.valid) begin
         crmd_plv_nxt = 2'b00;
         crmd_ie_nxt = 1'b0;
         prmd_pplv_nxt = crmd_plv;
         prmd_pie_nxt = crmd_ie;
      end else if (exc.ertn) begin
         crmd_plv_nxt = prmd_pplv;
         crmd_ie_nxt = prmd_pie;
      end else begin
         if (wsel_en[csr_pkg::sel_crmd]) begin
            crmd_plv_nxt = (crmd_plv & keep[csr_pkg::crmd_plv_hi:csr_pkg::crmd_plv_lo])
                         | wbits[csr_pkg::crmd_plv_hi:csr_pkg::crmd_plv_lo];
            crmd_ie_nxt = (crmd_ie & keep[csr_pkg::crmd_ie_bit])
                        | wbits[csr_pkg::crmd_ie_bit];
         end
         if (wsel_en[csr_pkg::sel_prmd]) begin
            prmd_pplv_nxt = (prmd_pplv & keep[csr_pkg::prmd_pplv_hi:csr_pkg::prmd_pplv_lo])
                          | wbits[csr_pkg::prmd_pplv_hi:csr_pkg::prmd_pplv_lo];
            prmd_pie_nxt = (prmd_pie & keep[csr_pkg::prmd_pie_bit])
                         | wbits[csr_pkg::prmd_pie_bit];
         end
      end
   end

   // tcfg as it will be after this edge, the timer starts from it
   always_comb begin
      tcfg_en_nxt = tcfg_en;
      tcfg_periodic_nxt = tcfg_periodic;
      tcfg_initval_nxt = tcfg_initval;
      if (wsel_en[csr_pkg::sel_tcfg]) begin
         tcfg_en_nxt = (tcfg_en & keep[csr_pkg::tcfg_en_bit])
                     | wbits[csr_pkg::tcfg_en_bit];
         tcfg_periodic_nxt = (tcfg_periodic & keep[csr_pkg::tcfg_periodic_bit])
                           | wbits[csr_pkg::tcfg_periodic_bit];
         tcfg_initval_nxt = (tcfg_initval & keep[csr_pkg::grlen-1:csr_pkg::tcfg_initval_lo])
                          | wbits[csr_pkg::grlen-1:csr_pkg::tcfg_initval_lo];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         crmd_plv <= '0;
         crmd_ie <= 1'b0;
         prmd_pplv <= '0;
         prmd_pie <= 1'b0;
         estat_sis <= '0;
         estat_ecode <= '0;
         era <= '0;
         badv <= '0;
         eentry <= '0;
         tcfg_en <= 1'b0;
         tcfg_periodic <= 1'b0;
         tcfg_initval <= '0;
         timer_intr <= 1'b0;
         bsec_ef <= 1'b0;
      end else begin
         crmd_plv <= crmd_plv_nxt;
         crmd_ie <= crmd_ie_nxt;
         prmd_pplv <= prmd_pplv_nxt;
         prmd_pie <= prmd_pie_nxt;
         tcfg_en <= tcfg_en_nxt;
         tcfg_periodic <= tcfg_periodic_nxt;
         tcfg_initval <= tcfg_initval_nxt;
         if (wsel_en[csr_pkg::sel_estat]) begin
            estat_sis <= (estat_sis & keep[csr_pkg::estat_sis_hi:csr_pkg::estat_sis_lo])
                       | wbits[csr_pkg::estat_sis_hi:csr_pkg::estat_sis_lo];
         end
         if (exc.valid) begin
            estat_ecode <= exc.ecode;
            era <= exc.pc;
            badv <= exc.badv;
         end else begin
            if (wsel_en[csr_pkg::sel_era]) begin
               era <= (era & keep) | wbits;
            end
            if (wsel_en[csr_pkg::sel_badv]) begin
               badv <= (badv & keep) | wbits;
            end
         end
         if (wsel_en[csr_pkg::sel_eentry]) begin
            eentry <= (eentry & keep) | wbits;
         end
         // a new pulse beats a clear in the same cycle
         timer_intr <= timer_pulse | (timer_intr & ~ti_clear);
         // sticky until reset
         bsec_ef <= bsec_ef | (wsel_en[csr_pkg::sel_bsec] & wbits[csr_pkg::bsec_ef_bit]);
      end
   end

   csr_timer u_timer (
      .clk      (clk),
      .rst_n    (rst_n),
      .init     (wsel_en[csr_pkg::sel_tcfg]),
      .en       (tcfg_en_nxt),
      .periodic (tcfg_periodic_nxt),
      .initval  (tcfg_initval_nxt),
      .timeval  (timeval),
      .intr     (timer_pulse)
   );

   // read words, ticlr always reads zero
   always_comb begin
      csr_word = '0;
      csr_word[csr_pkg::sel_crmd][csr_pkg::crmd_plv_hi:csr_pkg::crmd_plv_lo] = crmd_plv;
      csr_word[csr_pkg::sel_crmd][csr_pkg::crmd_ie_bit] = crmd_ie;
      csr_word[csr_pkg::sel_prmd][csr_pkg::prmd_pplv_hi:csr_pkg::prmd_pplv_lo] = prmd_pplv;
      csr_word[csr_pkg::sel_prmd][csr_pkg::prmd_pie_bit] = prmd_pie;
      csr_word[csr_pkg::sel_estat][csr_pkg::estat_sis_hi:csr_pkg::estat_sis_lo] = estat_sis;
      csr_word[csr_pkg::sel_estat][csr_pkg::estat_ipi_bit] = 1'b0;
      csr_word[csr_pkg::sel_estat][csr_pkg::estat_ti_bit] = timer_intr;
      // external line goes straight into the read path
      csr_word[csr_pkg::sel_estat][csr_pkg::estat_hwi0_bit] = ext_intr;
      csr_word[csr_pkg::sel_estat][csr_pkg::estat_ecode_hi:csr_pkg::estat_ecode_lo] =
         estat_ecode;
      csr_word[csr_pkg::sel_era] = era;
      csr_word[csr_pkg::sel_badv] = badv;
      csr_word[csr_pkg::sel_eentry] = eentry;
      csr_word[csr_pkg::sel_tcfg][csr_pkg::tcfg_en_bit] = tcfg_en;
      csr_word[csr_pkg::sel_tcfg][csr_pkg::tcfg_periodic_bit] = tcfg_periodic;
      csr_word[csr_pkg::sel_tcfg][csr_pkg::grlen-1:csr_pkg::tcfg_initval_lo] = tcfg_initval;
      csr_word[csr_pkg::sel_tval] = timeval;
      csr_word[csr_pkg::sel_bsec][csr_pkg::bsec_ef_bit] = bsec_ef;
   end

   // and-or mux, unmapped address gives zero
   always_comb begin
      rdata = '0;
      for (int i = 0; i < csr_pkg::num_csr; i++) begin
         rdata = rdata | (csr_word[i] & {csr_pkg::grlen{sel.rsel[i]}});
      end
   end

   always_ff @(posedge clk) begin
      if (sel.valid) begin
         rsp.rdata <= rdata;
      end
      if (!rst_n) begin
         rsp.valid <= 1'b0;
      end else begin
         rsp.valid <= sel.valid;
      end
   end

   // execute never raises an exception and a return together
   a_exc_ertn_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(exc.valid && exc.ertn)
   ) else $error("csr_file: exception and ertn in the same cycle");

endmodule

// File: source/csr_timer.sv
module csr_timer (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           init,
   input  logic                           en,
   input  logic                           periodic,
   input  logic [csr_pkg::timer_bits-1:0] initval,
   output logic [csr_pkg::grlen-1:0]      timeval,
   output logic                           intr
);

   logic [csr_pkg::grlen-1:0] count;
   // cleared once a one-shot run has fired
   logic                      armed;
   logic                      fire;

   // zero reached while counting, and no pulse last cycle
   assign fire = en & armed & (count == '0) & ~intr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
         armed <= 1'b0;
         intr <= 1'b0;
      end else if (init) begin
         count <= {initval, 2'b00};
         armed <= 1'b1;
         intr <= 1'b0;
      end else begin
         intr <= fire;
         if (fire) begin
            if (periodic) begin
               count <= {initval, 2'b00};
            end else begin
               armed <= 1'b0;
            end
         end else if (en && count != '0) begin
            count <= count - 1'b1;
         end
      end
   end

   assign timeval = count;

   // the TI flag in csr_file relies on single-cycle pulses
   a_intr_single: assert property (
      @(posedge clk) disable iff (!rst_n)
      intr |=> !intr
   ) else $error("csr_timer: interrupt pulse longer than one cycle");

endmodule

// File: source/csr_decode.sv
module csr_decode (
   input  logic              clk,
   input  logic              rst_n,
   input  csr_pkg::csr_req_t req,
   output csr_pkg::csr_sel_t sel
);

   // address to one-hot register select, all zero when unmapped
   function automatic logic [csr_pkg::num_csr-1:0] addr_onehot(
      input logic [csr_pkg::csr_addr_bits-1:0] addr
   );
      logic [csr_pkg::num_csr-1:0] hit;
      hit = '0;
      hit[csr_pkg::sel_crmd] = (addr == csr_pkg::addr_crmd);
      hit[csr_pkg::sel_prmd] = (addr == csr_pkg::addr_prmd);
      hit[csr_pkg::sel_estat] = (addr == csr_pkg::addr_estat);
      hit[csr_pkg::sel_era] = (addr == csr_pkg::addr_era);
      hit[csr_pkg::sel_badv] = (addr == csr_pkg::addr_badv);
      hit[csr_pkg::sel_eentry] = (addr == csr_pkg::addr_eentry);
      hit[csr_pkg::sel_tcfg] = (addr == csr_pkg::addr_tcfg);
      hit[csr_pkg::sel_tval] = (addr == csr_pkg::addr_tval);
      hit[csr_pkg::sel_ticlr] = (addr == csr_pkg::addr_ticlr);
      hit[csr_pkg::sel_bsec] = (addr == csr_pkg::addr_bsec);
      return hit;
   endfunction

   always_ff @(posedge clk) begin
      // payload only moves with a valid access
      if (req.valid) begin
         sel.rsel <= addr_onehot(req.raddr);
         sel.wsel <= addr_onehot(req.waddr);
         sel.wdata <= req.wdata;
         sel.mask <= req.mask;
      end
      if (!rst_n) begin
         sel.valid <= 1'b0;
         sel.wen <= 1'b0;
      end else begin
         sel.valid <= req.valid;
         // write is qualified here so stage two sees a clean enable
         sel.wen <= req.valid & req.wen;
      end
   end

   // the read mux in stage two ORs selected words, so two hits would corrupt rdata
   a_sel_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      sel.valid |-> ($onehot0(sel.rsel) && $onehot0(sel.wsel))
   ) else $error("csr_decode: select vector not one-hot");

endmodule

// File: source/csr_pkg.sv
package csr_pkg;

   localparam int grlen = 32;
   // initval sits above the two low config bits of tcfg
   localparam int timer_bits = 30;
   localparam int csr_addr_bits = 14;
   localparam int num_csr = 10;

   // csr addresses
   localparam logic [csr_addr_bits-1:0] addr_crmd = 14'h0;
   localparam logic [csr_addr_bits-1:0] addr_prmd = 14'h1;
   localparam logic [csr_addr_bits-1:0] addr_estat = 14'h5;
   localparam logic [csr_addr_bits-1:0] addr_era = 14'h6;
   localparam logic [csr_addr_bits-1:0] addr_badv = 14'h7;
   localparam logic [csr_addr_bits-1:0] addr_eentry = 14'hc;
   localparam logic [csr_addr_bits-1:0] addr_tcfg = 14'h41;
   localparam logic [csr_addr_bits-1:0] addr_tval = 14'h42;
   localparam logic [csr_addr_bits-1:0] addr_ticlr = 14'h44;
   localparam logic [csr_addr_bits-1:0] addr_bsec = 14'h100;

   // bit index of each register in the one-hot selects
   localparam int sel_crmd = 0;
   localparam int sel_prmd = 1;
   localparam int sel_estat = 2;
   localparam int sel_era = 3;
   localparam int sel_badv = 4;
   localparam int sel_eentry = 5;
   localparam int sel_tcfg = 6;
   localparam int sel_tval = 7;
   localparam int sel_ticlr = 8;
   localparam int sel_bsec = 9;

   // field positions
   localparam int crmd_plv_lo = 0;
   localparam int crmd_plv_hi = 1;
   localparam int crmd_ie_bit = 2;
   localparam int prmd_pplv_lo = 0;
   localparam int prmd_pplv_hi = 1;
   localparam int prmd_pie_bit = 2;
   localparam int estat_sis_lo = 0;
   localparam int estat_sis_hi = 1;
   localparam int estat_ipi_bit = 2;
   localparam int estat_ti_bit = 3;
   localparam int estat_hwi0_bit = 4;
   localparam int estat_ecode_lo = 16;
   localparam int estat_ecode_hi = 21;
   localparam int tcfg_en_bit = 0;
   localparam int tcfg_periodic_bit = 1;
   localparam int tcfg_initval_lo = 2;
   localparam int ticlr_clr_bit = 0;
   localparam int bsec_ef_bit = 0;

   typedef struct packed {
      logic                     valid;
      logic [csr_addr_bits-1:0] raddr;
      logic [csr_addr_bits-1:0] waddr;
      logic [grlen-1:0]         wdata;
      logic [grlen-1:0]         mask;
      logic                     wen;
   } csr_req_t;

   typedef struct packed {
      logic               valid;
      logic               wen;
      logic [num_csr-1:0] rsel;
      logic [num_csr-1:0] wsel;
      logic [grlen-1:0]   wdata;
      logic [grlen-1:0]   mask;
   } csr_sel_t;

   typedef struct packed {
      logic             valid;
      logic             ertn;
      logic [5:0]       ecode;
      logic [grlen-1:0] pc;
      logic [grlen-1:0] badv;
   } csr_exc_t;

   typedef struct packed {
      logic             valid;
      logic [grlen-1:0] rdata;
   } csr_rsp_t;

endpackage
